/* verilog/cps_video_params.svh */
// screen geometry for a 512x262 raster, sync windows sit inside blanking and must not include 0
`ifndef CPS_VIDEO_PARAMS_SVH
`define CPS_VIDEO_PARAMS_SVH

// horizontal geometry in pixels
`define CPS_HTOTAL      512
`define CPS_HVIS        384

// vertical geometry in lines
`define CPS_VTOTAL      262
`define CPS_VVIS        224

// sync windows, start inclusive and end exclusive
`define CPS_HS_START    416
`define CPS_HS_END      448
`define CPS_VS_START    236
`define CPS_VS_END      239

// colour code that lets the layer behind show through
`define CPS_TRANSP      4'hF

// word address widths of the external memories
`define CPS_VRAM_AW     23
`define CPS_ROM_AW      23

// palette depth, layer bit plus 9-bit pixel
`define CPS_PAL_AW      10

`endif

/* verilog/cps_video_pkg.sv */
// types shared by the video RTL and its testbench, widths follow the params header
`include "cps_video_params.svh"

package cps_video_pkg;

    // layer pixel as stored in the line buffers
    typedef struct packed {
        logic [4:0] pal;
        logic [3:0] code;
    } pixel_t;

    // raster counters
    typedef logic [8:0] hcount_t;
    typedef logic [7:0] vcount_t;

    // palette word, xRGB4
    typedef struct packed {
        logic [3:0] x;
        logic [3:0] r;
        logic [3:0] g;
        logic [3:0] b;
    } rgb_t;

    // memory word addresses
    typedef logic [`CPS_VRAM_AW-1:0] vram_addr_t;
    typedef logic [`CPS_ROM_AW-1:0]  rom_addr_t;

    // palette RAM index, layer bit then pixel
    typedef logic [`CPS_PAL_AW-1:0]  pal_addr_t;

endpackage

/* verilog/cps_video_timing.sv */
// vdump and vrender carry the low 8 bits of a 9-bit line count, so lines 256 to 261 alias onto 0 to 5
`include "cps_video_params.svh"

module cps_video_timing
    import cps_video_pkg::*;
(
    input  logic    clk,
    input  logic    reset,
    input  logic    pxl_cen,

    output hcount_t hdump,
    output vcount_t vdump,
    output vcount_t vrender,
    output logic    line_start,

    output logic    hsync,
    output logic    vsync,
    output logic    hblank,
    output logic    vblank
);

// full line counter with vdump as its low part
logic [8:0] vcnt;
logic [8:0] vnext;

assign vnext = (vcnt == 9'(`CPS_VTOTAL - 1)) ? 9'd0 : vcnt + 9'd1;

always_ff @(posedge clk) begin
    if (reset) begin
        hdump      <= '0;
        vcnt       <= '0;
        line_start <= 1'b0;
    end else begin
        line_start <= 1'b0;
        if (pxl_cen) begin
            if (hdump == hcount_t'(`CPS_HTOTAL - 1)) begin
                hdump      <= '0;
                vcnt       <= vnext;
                // lines up with hdump going back to 0
                line_start <= 1'b1;
            end else begin
                hdump <= hdump + 1'b1;
            end
        end
    end
end

assign vdump   = vcnt[7:0];
// the layers render one line ahead of the display
assign vrender = vnext[7:0];

// window decode straight from the counters
assign hblank = hdump >= hcount_t'(`CPS_HVIS);
assign vblank = vcnt >= 9'(`CPS_VVIS);
assign hsync  = (hdump >= hcount_t'(`CPS_HS_START)) && (hdump < hcount_t'(`CPS_HS_END));
assign vsync  = (vcnt >= 9'(`CPS_VS_START)) && (vcnt < 9'(`CPS_VS_END));

// pixel enable at half the clk rate gives each line the fetch budget of 1024 clks
a_cen_rate: assert property (
    @(posedge clk) disable iff (reset)
    pxl_cen |=> !pxl_cen
);

endmodule

/* verilog/cps_video_tilemap.sv */
// one line of fetch must finish before the next line_start, which needs memories answering in ~4 cycles
`include "cps_video_params.svh"

module cps_video_tilemap
    import cps_video_pkg::*;
#(
    parameter int SIZE = 8
)(
    input  logic        clk,
    input  logic        reset,
    input  logic        pxl_cen,

    input  logic        line_start,
    input  vcount_t     vrender,
    input  hcount_t     hdump,

    input  logic [15:0] vram_base,
    input  logic [15:0] hpos,
    input  logic [15:0] vpos,

    output vram_addr_t  vram_addr,
    input  logic [15:0] vram_data,
    output logic        vram_cs,
    input  logic        vram_ok,

    output rom_addr_t   rom_addr,
    input  logic [31:0] rom_data,
    output logic        rom_cs,
    input  logic        rom_ok,
    output logic        rom_half,

    output pixel_t      pxl
);

// row bits inside a tile and tiles needed to cover the visible width
localparam int RW     = $clog2(SIZE);
localparam int NTILES = `CPS_HVIS / SIZE + 1;

typedef enum logic [2:0] {
    ST_IDLE,
    ST_CODE,
    ST_ATTR,
    ST_ROM,
    ST_LOAD
} state_t;

state_t          state;
logic            bank;
logic [15:0]     ypos;
logic [5:0]      col;
logic [5:0]      trow;
logic [RW-1:0]   rrow;
logic [5:0]      tile_cnt;
hcount_t         buf_x;
logic            half_idx;
logic [15:0]     code;
logic [4:0]      pal;
logic            xflip;
logic [31:0]     romw;
logic            upk_ld;

// unpacker state
logic [3:0]      upk_cnt;
logic [31:0]     upk_data;
hcount_t         upk_x;
logic [4:0]      upk_pal;

// two halves of 512 pixels, bank selects the one on screen
pixel_t          line_buf [0:1023];

// entries are two words, rows wrap at 64 tiles
function automatic vram_addr_t entry_addr(
    input logic [15:0] base,
    input logic [5:0]  row,
    input logic [5:0]  column
);
    entry_addr = vram_addr_t'(base) + vram_addr_t'({row, column, 1'b0});
endfunction

// pixel 0 is the top nibble, mirroring reverses the nibble order
function automatic logic [31:0] nib_rev(input logic [31:0] w);
    for (int i = 0; i < 8; i++) begin
        nib_rev[4*i +: 4] = w[28-4*i +: 4];
    end
endfunction

assign ypos   = {8'd0, vrender} + vpos;
assign upk_ld = (state == ST_LOAD) && (upk_cnt <= 4'd1);

always_ff @(posedge clk) begin
    if (reset) begin
        state    <= ST_IDLE;
        bank     <= 1'b0;
        vram_cs  <= 1'b0;
        rom_cs   <= 1'b0;
        rom_half <= 1'b0;
        half_idx <= 1'b0;
    end else begin
        if (line_start) begin
            bank <= ~bank;
        end
        case (state)
            ST_IDLE: begin
                if (line_start) begin
                    trow      <= ypos[RW +: 6];
                    rrow      <= ypos[RW-1:0];
                    col       <= hpos[RW +: 6];
                    tile_cnt  <= '0;
                    // fine scroll pushes the first tile left of column 0
                    buf_x     <= hcount_t'(0) - hcount_t'(hpos[RW-1:0]);
                    vram_addr <= entry_addr(vram_base, ypos[RW +: 6], hpos[RW +: 6]);
                    vram_cs   <= 1'b1;
                    state     <= ST_CODE;
                end
            end
            ST_CODE: begin
                if (vram_ok) begin
                    code      <= vram_data;
                    vram_addr <= vram_addr + 1'b1;
                    state     <= ST_ATTR;
                end
            end
            ST_ATTR: begin
                if (vram_ok) begin
                    pal      <= vram_data[4:0];
                    xflip    <= vram_data[5];
                    vram_cs  <= 1'b0;
                    // y flip mirrors the row inside the tile
                    rom_addr <= rom_addr_t'({code, rrow ^ {RW{vram_data[6]}}});
                    // mirrored wide tiles start from the right half
                    rom_half <= (SIZE == 16) ? vram_data[5] : 1'b0;
                    half_idx <= 1'b0;
                    rom_cs   <= 1'b1;
                    state    <= ST_ROM;
                end
            end
            ST_ROM: begin
                if (rom_ok) begin
                    romw   <= rom_data;
                    rom_cs <= 1'b0;
                    state  <= ST_LOAD;
                end
            end
            ST_LOAD: begin
                // wait for the unpacker to take the word
                if (upk_ld) begin
                    if (SIZE == 16 && !half_idx) begin
                        half_idx <= 1'b1;
                        rom_half <= ~rom_half;
                        rom_cs   <= 1'b1;
                        state    <= ST_ROM;
                    end else begin
                        tile_cnt <= tile_cnt + 1'b1;
                        buf_x    <= buf_x + hcount_t'(SIZE);
                        col      <= col + 1'b1;
                        if (tile_cnt == 6'(NTILES - 1)) begin
                            state <= ST_IDLE;
                        end else begin
                            vram_addr <= entry_addr(vram_base, trow, col + 1'b1);
                            vram_cs   <= 1'b1;
                            state     <= ST_CODE;
                        end
                    end
                end
            end
            default: state <= ST_IDLE;
        endcase
    end
end

// unpacker writes one pixel per clk into the back half
always_ff @(posedge clk) begin
    if (reset) begin
        upk_cnt <= '0;
    end else if (upk_ld) begin
        upk_cnt <= 4'd8;
    end else if (upk_cnt != 0) begin
        upk_cnt <= upk_cnt - 1'b1;
    end
end

always_ff @(posedge clk) begin
    if (upk_ld) begin
        upk_data <= xflip ? nib_rev(romw) : romw;
        upk_x    <= buf_x + hcount_t'({half_idx, 3'b000});
        upk_pal  <= pal;
    end else if (upk_cnt != 0) begin
        upk_data <= {upk_data[27:0], 4'h0};
        upk_x    <= upk_x + 1'b1;
    end
end

always_ff @(posedge clk) begin
    if (upk_cnt != 0) begin
        line_buf[{~bank, upk_x}] <= '{pal: upk_pal, code: upk_data[31:28]};
    end
end

// front half follows the raster
always_ff @(posedge clk) begin
    if (pxl_cen) begin
        pxl <= line_buf[{bank, hdump}];
    end
end

// memories see a steady request until they answer
a_vram_hold: assert property (
    @(posedge clk) disable iff (reset)
    vram_cs && !vram_ok |=> vram_cs && $stable(vram_addr)
);

a_rom_hold: assert property (
    @(posedge clk) disable iff (reset)
    rom_cs && !rom_ok |=> rom_cs && $stable(rom_addr) && $stable(rom_half)
);

// the previous line must be fully written when the buffers swap
a_fetch_done: assert property (
    @(posedge clk) disable iff (reset)
    line_start |-> state == ST_IDLE && upk_cnt == 0
);

endmodule

/* verilog/cps_video_colmix.sv */
// rgb and its blanking lag hdump by two pixel clocks, palette writes are not arbitrated with reads
`include "cps_video_params.svh"

module cps_video_colmix
    import cps_video_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  logic      pxl_cen,

    input  logic      hblank,
    input  logic      vblank,

    input  pixel_t    scr1_pxl,
    input  pixel_t    scr2_pxl,

    input  logic      pal_we,
    input  pal_addr_t pal_addr,
    input  rgb_t      pal_data,

    output logic [7:0] red,
    output logic [7:0] green,
    output logic [7:0] blue
);

rgb_t      pal_ram [0:(1 << `CPS_PAL_AW) - 1];
pal_addr_t pal_idx;
rgb_t      rgb_q;
logic      blank_d;
logic      blank_q;

always_ff @(posedge clk) begin
    if (pal_we) begin
        pal_ram[pal_addr] <= pal_data;
    end
end

// scroll 1 in front, entry 0 when both layers are clear
always_comb begin
    if (scr1_pxl.code != `CPS_TRANSP) begin
        pal_idx = {1'b0, scr1_pxl};
    end else if (scr2_pxl.code != `CPS_TRANSP) begin
        pal_idx = {1'b1, scr2_pxl};
    end else begin
        pal_idx = '0;
    end
end

// blank follows the same two stages as the pixel
always_ff @(posedge clk) begin
    if (reset) begin
        blank_d <= 1'b1;
        blank_q <= 1'b1;
    end else if (pxl_cen) begin
        blank_d <= hblank | vblank;
        blank_q <= blank_d;
    end
end

always_ff @(posedge clk) begin
    if (pxl_cen) begin
        rgb_q <= pal_ram[pal_idx];
    end
end

// 4 to 8 bits by repeating the nibble
assign red   = blank_q ? 8'd0 : {rgb_q.r, rgb_q.r};
assign green = blank_q ? 8'd0 : {rgb_q.g, rgb_q.g};
assign blue  = blank_q ? 8'd0 : {rgb_q.b, rgb_q.b};

endmodule

/* verilog/cps_video.sv */
// two tile layers only, both memory ports per layer use a cs/ok handshake held until ok
module cps_video
    import cps_video_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  logic        pxl_cen,

    output hcount_t     hdump,
    output vcount_t     vdump,
    output logic        hsync,
    output logic        vsync,
    output logic        hblank,
    output logic        vblank,

    // layer registers
    input  logic [15:0] hpos1,
    input  logic [15:0] vpos1,
    input  logic [15:0] vram1_base,
    input  logic [15:0] hpos2,
    input  logic [15:0] vpos2,
    input  logic [15:0] vram2_base,

    // video RAM
    output vram_addr_t  vram1_addr,
    input  logic [15:0] vram1_data,
    output logic        vram1_cs,
    input  logic        vram1_ok,
    output vram_addr_t  vram2_addr,
    input  logic [15:0] vram2_data,
    output logic        vram2_cs,
    input  logic        vram2_ok,

    // graphics ROM
    output rom_addr_t   rom1_addr,
    input  logic [31:0] rom1_data,
    output logic        rom1_cs,
    input  logic        rom1_ok,
    output logic        rom1_half,
    output rom_addr_t   rom2_addr,
    input  logic [31:0] rom2_data,
    output logic        rom2_cs,
    input  logic        rom2_ok,
    output logic        rom2_half,

    // palette
    input  logic        pal_we,
    input  pal_addr_t   pal_addr,
    input  rgb_t        pal_data,

    output logic [7:0]  red,
    output logic [7:0]  green,
    output logic [7:0]  blue
);

vcount_t vrender;
logic    line_start;
pixel_t  scr1_pxl;
pixel_t  scr2_pxl;

cps_video_timing u_timing (
    .clk        (clk),
    .reset      (reset),
    .pxl_cen    (pxl_cen),
    .hdump      (hdump),
    .vdump      (vdump),
    .vrender    (vrender),
    .line_start (line_start),
    .hsync      (hsync),
    .vsync      (vsync),
    .hblank     (hblank),
    .vblank     (vblank)
);

// scroll 1, 8x8 tiles
cps_video_tilemap #(.SIZE(8)) u_scroll1 (
    .clk        (clk),
    .reset      (reset),
    .pxl_cen    (pxl_cen),
    .line_start (line_start),
    .vrender    (vrender),
    .hdump      (hdump),
    .vram_base  (vram1_base),
    .hpos       (hpos1),
    .vpos       (vpos1),
    .vram_addr  (vram1_addr),
    .vram_data  (vram1_data),
    .vram_cs    (vram1_cs),
    .vram_ok    (vram1_ok),
    .rom_addr   (rom1_addr),
    .rom_data   (rom1_data),
    .rom_cs     (rom1_cs),
    .rom_ok     (rom1_ok),
    .rom_half   (rom1_half),
    .pxl        (scr1_pxl)
);

// scroll 2, 16x16 tiles
cps_video_tilemap #(.SIZE(16)) u_scroll2 (
    .clk        (clk),
    .reset      (reset),
    .pxl_cen    (pxl_cen),
    .line_start (line_start),
    .vrender    (vrender),
    .hdump      (hdump),
    .vram_base  (vram2_base),
    .hpos       (hpos2),
    .vpos       (vpos2),
    .vram_addr  (vram2_addr),
    .vram_data  (vram2_data),
    .vram_cs    (vram2_cs),
    .vram_ok    (vram2_ok),
    .rom_addr   (rom2_addr),
    .rom_data   (rom2_data),
    .rom_cs     (rom2_cs),
    .rom_ok     (rom2_ok),
    .rom_half   (rom2_half),
    .pxl        (scr2_pxl)
);

cps_video_colmix u_colmix (
    .clk        (clk),
    .reset      (reset),
    .pxl_cen    (pxl_cen),
    .hblank     (hblank),
    .vblank     (vblank),
    .scr1_pxl   (scr1_pxl),
    .scr2_pxl   (scr2_pxl),
    .pal_we     (pal_we),
    .pal_addr   (pal_addr),
    .pal_data   (pal_data),
    .red        (red),
    .green      (green),
    .blue       (blue)
);

endmodule

/* dv/cps_video_tb.sv */
// runs from the project root so that dv/cps_video_stim.txt resolves, and only frames 1 and up are checked
module cps_video_tb
    import cps_video_pkg::*;
();

timeunit 1ns;
timeprecision 1ps;

localparam logic [31:0] SEED = 32'h9a4e_9a3e;
localparam longint FRAME_NS = 262 * 512 * 16;

logic        clk;
logic        reset;
logic        pxl_cen;
hcount_t     hdump;
vcount_t     vdump;
logic        hsync;
logic        vsync;
logic        hblank;
logic        vblank;
logic [15:0] hpos1;
logic [15:0] vpos1;
logic [15:0] vram1_base;
logic [15:0] hpos2;
logic [15:0] vpos2;
logic [15:0] vram2_base;
vram_addr_t  vram1_addr;
logic [15:0] vram1_data;
logic        vram1_cs;
logic        vram1_ok;
vram_addr_t  vram2_addr;
logic [15:0] vram2_data;
logic        vram2_cs;
logic        vram2_ok;
rom_addr_t   rom1_addr;
logic [31:0] rom1_data;
logic        rom1_cs;
logic        rom1_ok;
logic        rom1_half;
rom_addr_t   rom2_addr;
logic [31:0] rom2_data;
logic        rom2_cs;
logic        rom2_ok;
logic        rom2_half;
logic        pal_we;
pal_addr_t   pal_addr;
rgb_t        pal_data;
logic [7:0]  red;
logic [7:0]  green;
logic [7:0]  blue;

// attribute word per layer, set from the stim file
logic [15:0] attr1;
logic [15:0] attr2;
int          frame_cnt;
longint      limit_ns;
int          lat_v1;
int          lat_v2;
int          lat_r1;
int          lat_r2;

// parsed stimulus, eight arguments per record
int          kind_q[$];
string       name_q[$];
int          arg_q[$];
int          max_frame;

cps_video u_dut (.*);

initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
end

initial begin
    pxl_cen = 1'b0;
    forever begin
        @(posedge clk);
        #1 pxl_cen = ~pxl_cen;
    end
end

// code word is the entry index, attribute word comes from the table
function automatic logic [15:0] vram_word(input int layer, input vram_addr_t a);
    if (a[0]) begin
        vram_word = (layer == 1) ? attr1 : attr2;
    end else begin
        vram_word = {8'h00, a[8:1]};
    end
endfunction

// nibble of pixel p is tile code plus row plus pixel position
function automatic logic [31:0] rom_word(input int layer, input rom_addr_t r, input logic half);
    logic [3:0]  base;
    logic [31:0] w;
    base = (layer == 1) ? r[6:3] + r[2:0] : r[7:4] + r[3:0] + {half, 3'b000};
    for (int p = 0; p < 8; p++) begin
        w[31 - 4*p -: 4] = base + 4'(p);
    end
    rom_word = w;
endfunction

// memory models answer after 1 to 4 cycles, ok drops once taken
always @(posedge clk) begin
    #1;
    if (vram1_ok) begin
        vram1_ok = 1'b0;
        lat_v1   = $urandom % 4;
    end else if (vram1_cs) begin
        if (lat_v1 == 0) begin
            vram1_data = vram_word(1, vram1_addr);
            vram1_ok   = 1'b1;
        end else begin
            lat_v1--;
        end
    end
end

always @(posedge clk) begin
    #1;
    if (vram2_ok) begin
        vram2_ok = 1'b0;
        lat_v2   = $urandom % 4;
    end else if (vram2_cs) begin
        if (lat_v2 == 0) begin
            vram2_data = vram_word(2, vram2_addr);
            vram2_ok   = 1'b1;
        end else begin
            lat_v2--;
        end
    end
end

always @(posedge clk) begin
    #1;
    if (rom1_ok) begin
        rom1_ok = 1'b0;
        lat_r1  = $urandom % 4;
    end else if (rom1_cs) begin
        if (lat_r1 == 0) begin
            rom1_data = rom_word(1, rom1_addr, rom1_half);
            rom1_ok   = 1'b1;
        end else begin
            lat_r1--;
        end
    end
end

always @(posedge clk) begin
    #1;
    if (rom2_ok) begin
        rom2_ok = 1'b0;
        lat_r2  = $urandom % 4;
    end else if (rom2_cs) begin
        if (lat_r2 == 0) begin
            rom2_data = rom_word(2, rom2_addr, rom2_half);
            rom2_ok   = 1'b1;
        end else begin
            lat_r2--;
        end
    end
end

// frame advances when the last line wraps to line 0
always @(posedge clk) begin
    if (reset) begin
        frame_cnt <= 0;
    end else if (pxl_cen && hdump == 9'd511 && vdump == 8'd5 && vblank) begin
        frame_cnt <= frame_cnt + 1;
    end
end

task automatic check_rgb(input string name, input rgb_t exp, input logic [7:0] r,
                         input logic [7:0] g, input logic [7:0] b);
    logic [23:0] e;
    e = {exp.r, exp.r, exp.g, exp.g, exp.b, exp.b};
    if ({r, g, b} !== e) begin
        $display("[ERROR] %s rgb: expected %h, actual %h", name, e, {r, g, b});
        $display("sim failed");
        $fatal(1);
    end
endtask

task automatic check_flags(input string name, input logic [3:0] exp, input logic [3:0] act);
    if (act !== exp) begin
        $display("[ERROR] %s hs/vs/hb/vb: expected %b, actual %b", name, exp, act);
        $display("sim failed");
        $fatal(1);
    end
endtask

task automatic load_stim();
    int    fd;
    int    n;
    int    k;
    int    a[8];
    string line;
    string tok;
    string name;
    fd = $fopen("dv/cps_video_stim.txt", "r");
    if (fd == 0) begin
        $display("could not open the stimulus file dv/cps_video_stim.txt");
        $display("sim failed");
        $fatal(1);
    end
    while (!$feof(fd)) begin
        line = "";
        n = $fgets(line, fd);
        if (n > 0 && line.len() > 1 && line[0] != "#") begin
            name = "";
            a = '{default: 0};
            n = $sscanf(line, "%s", tok);
            if (tok == "reg") begin
                k = 0;
                n = $sscanf(line, "%s %h %h %h %h %h %h %h %h", tok,
                            a[0], a[1], a[2], a[3], a[4], a[5], a[6], a[7]);
            end else if (tok == "pal") begin
                k = 1;
                n = $sscanf(line, "%s %h %h", tok, a[0], a[1]);
            end else if (tok == "chk") begin
                k = 2;
                n = $sscanf(line, "%s %s %d %d %d %h %b", tok, name,
                            a[0], a[1], a[2], a[3], a[4]);
                if (a[0] > max_frame) begin
                    max_frame = a[0];
                end
            end else begin
                $display("unknown command in the stimulus file: %s", line);
                $display("sim failed");
                $fatal(1);
            end
            kind_q.push_back(k);
            name_q.push_back(name);
            for (int j = 0; j < 8; j++) begin
                arg_q.push_back(a[j]);
            end
        end
    end
    $fclose(fd);
endtask

// palette entry i holds r = i[3:0], g = i[7:4], b = i[9:8]
task automatic fill_palette();
    for (int i = 0; i < 1024; i++) begin
        @(posedge clk);
        #1;
        pal_we   = 1'b1;
        pal_addr = pal_addr_t'(i);
        pal_data = rgb_t'({4'h0, i[3:0], i[7:4], 2'b00, i[9:8]});
    end
    @(posedge clk);
    #1 pal_we = 1'b0;
endtask

task automatic run_sample(input string name, input int f, input int l, input int c,
                          input int rgbv, input int flg);
    do begin
        @(negedge clk);
    end while (!(frame_cnt == f && vdump == vcount_t'(l) && hdump == hcount_t'(c + 2)));
    check_rgb(name, rgb_t'(16'(rgbv)), red, green, blue);
    check_flags(name, 4'(flg), {hsync, vsync, hblank, vblank});
endtask

// watchdog, armed once the frame count is known
initial begin
    wait (limit_ns > 0);
    #(limit_ns);
    $display("timeout: the expected raster positions were not reached in time");
    $display("sim failed");
    $fatal(1);
end

initial begin
    int b;
    void'($urandom(SEED));
    reset      = 1'b1;
    hpos1      = '0;
    vpos1      = '0;
    vram1_base = '0;
    hpos2      = '0;
    vpos2      = '0;
    vram2_base = '0;
    vram1_data = '0;
    vram1_ok   = 1'b0;
    vram2_data = '0;
    vram2_ok   = 1'b0;
    rom1_data  = '0;
    rom1_ok    = 1'b0;
    rom2_data  = '0;
    rom2_ok    = 1'b0;
    pal_we     = 1'b0;
    pal_addr   = '0;
    pal_data   = '0;
    attr1      = '0;
    attr2      = '0;
    lat_v1     = 0;
    lat_v2     = 0;
    lat_r1     = 0;
    lat_r2     = 0;
    limit_ns   = 0;
    max_frame  = 0;
    load_stim();
    limit_ns = longint'(max_frame + 2) * FRAME_NS + 100_000;
    repeat (16) @(posedge clk);
    #1 reset = 1'b0;
    fill_palette();
    for (int i = 0; i < kind_q.size(); i++) begin
        b = 8 * i;
        if (kind_q[i] == 0) begin
            @(posedge clk);
            #1;
            hpos1      = 16'(arg_q[b]);
            vpos1      = 16'(arg_q[b + 1]);
            vram1_base = 16'(arg_q[b + 2]);
            attr1      = 16'(arg_q[b + 3]);
            hpos2      = 16'(arg_q[b + 4]);
            vpos2      = 16'(arg_q[b + 5]);
            vram2_base = 16'(arg_q[b + 6]);
            attr2      = 16'(arg_q[b + 7]);
        end else if (kind_q[i] == 1) begin
            @(posedge clk);
            #1;
            pal_we   = 1'b1;
            pal_addr = pal_addr_t'(arg_q[b]);
            pal_data = rgb_t'(16'(arg_q[b + 1]));
            @(posedge clk);
            #1 pal_we = 1'b0;
        end else begin
            run_sample(name_q[i], arg_q[b], arg_q[b + 1], arg_q[b + 2],
                       arg_q[b + 3], arg_q[b + 4]);
        end
    end
    $display("sim passed");
    $finish;
end

endmodule

/* dv/cps_video_stim.txt */
# reg  hpos1 vpos1 base1 attr1 hpos2 vpos2 base2 attr2 (hex)   pal  addr data (hex)
# chk  name frame line col rgb(hex xRGB4 low 12 bits) flags(hsync vsync hblank vblank at hdump col+2)
reg 0000 0000 0000 0005 0000 0000 4000 001a
pal 000 0123
# frame 1, no scroll, no flips
chk zero   1 10 0   250 0000
chk zero   1 10 19  750 0000
chk transp 1 10 55  4a3 0000
chk blank  1 10 390 000 0010
chk sync   1 10 420 000 1010
chk transp 1 16 120 123 0000
chk zero   1 100 200 d50 0000
chk blank  1 230 430 000 1011
chk sync   1 237 100 000 0101
# frame 2, both layers scrolled
reg 0013 0005 0000 0005 0025 0009 4000 001a
chk scroll 2 20 3   950 0000
chk scroll 2 20 44  3a3 0000
chk scroll 2 20 51  aa3 0000
chk scroll 2 20 100 650 0000
chk scroll 2 150 250 950 0000
# frame 3, x and y flip on both layers
reg 0000 0000 0000 0065 0000 0000 4000 007a
chk flip   3 10 0   c50 0000
chk flip   3 10 19  b50 0000
chk flip   3 10 24  da3 0000
chk flip   3 10 33  5a3 0000
chk flip   3 100 200 350 0000

/* cps_video.f */
+incdir+verilog
verilog/cps_video_pkg.sv
verilog/cps_video_timing.sv
verilog/cps_video_tilemap.sv
verilog/cps_video_colmix.sv
verilog/cps_video.sv
dv/cps_video_tb.sv

/* Bender.yml */
package:
  name: cps_video

export_include_dirs:
  - verilog

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/cps_video_pkg.sv
      - verilog/cps_video_timing.sv
      - verilog/cps_video_tilemap.sv
      - verilog/cps_video_colmix.sv
      - verilog/cps_video.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - dv/cps_video_tb.sv
